//--- hdl/mult_pkg.sv
package mult_pkg;

    // Operand and result width of the execute stage datapath
    localparam int WORD_WIDTH = 32;

    typedef logic [WORD_WIDTH-1:0] word_t;

    // Full double-width product, high word on top
    typedef logic [2*WORD_WIDTH-1:0] product_t;

    // Cycles from accepted operands to product out of the multiplier element
    // Three register stages are fixed inside the element
    localparam int ELEMENT_LATENCY = 4;

    localparam int PAD_DEPTH = ELEMENT_LATENCY - 3; // Padding added by the delay line

    // One more cycle for the registered word select at the output
    localparam int UNIT_LATENCY = ELEMENT_LATENCY + 1;

    // Value 3 is reserved and must not be issued
    typedef enum logic [1:0] {
        op_mul   = 2'd0, // Low word, same for signed and unsigned
        op_mulh  = 2'd1, // High word, signed x signed
        op_mulhu = 2'd2  // High word, unsigned x unsigned
    } mult_op_t;

endpackage

//--- hdl/delay_line.sv
module delay_line #(
    parameter int depth = 1,
    parameter int width = 1
) (
    input  logic             clock,
    input  logic             rst,
    input  logic [width-1:0] in,
    output logic [width-1:0] out
);

    generate
        if (depth == 0) begin : g_wire
            // No stages requested so the value passes straight through
            assign out = in;
        end else begin : g_chain
            logic [width-1:0] stage [depth];

            always_ff @(posedge clock) begin
                if (rst) begin
                    for (int i = 0; i < depth; i++) begin
                        stage[i] <= '0;
                    end
                end else begin
                    stage[0] <= in;
                    for (int i = 1; i < depth; i++) begin
                        stage[i] <= stage[i-1]; // Shift one stage per cycle
                    end
                end
            end

            assign out = stage[depth-1];
        end
    endgenerate

endmodule

//--- hdl/mult_element.sv
module mult_element
    import mult_pkg::*;
(
    input  logic     clock,
    input  logic     rst,
    input  logic     sign,
    input  word_t    dataa,
    input  word_t    datab,
    output product_t product
);

    word_t    dataa_q;
    word_t    datab_q;
    logic     sign_q;
    product_t ext_a;
    product_t ext_b;
    product_t mult_q;
    product_t out_q;

    // The three built-in stages leave no room for a shorter pipeline
    if (ELEMENT_LATENCY < 3) begin : g_latency_check
        $error("ELEMENT_LATENCY must be at least 3");
    end

    // Stage one holds operands and sign
    always_ff @(posedge clock) begin
        dataa_q <= dataa;
        datab_q <= datab;
        sign_q  <= sign;
    end

    // Extend both operands to two words by the registered sign
    always_comb begin
        if (sign_q) begin
            ext_a = {{WORD_WIDTH{dataa_q[WORD_WIDTH-1]}}, dataa_q};
            ext_b = {{WORD_WIDTH{datab_q[WORD_WIDTH-1]}}, datab_q};
        end else begin
            ext_a = {{WORD_WIDTH{1'b0}}, dataa_q};
            ext_b = {{WORD_WIDTH{1'b0}}, datab_q};
        end
    end

    // Product modulo two words is exact for both signed and unsigned operands
    always_ff @(posedge clock) begin
        mult_q <= ext_a * ext_b;
    end

    always_ff @(posedge clock) begin
        out_q <= mult_q; // Output register is always present
    end

    // Remaining latency comes from the padding stages
    delay_line #(
        .depth (PAD_DEPTH),
        .width ($bits(product_t))
    ) i_latency_adjuster (
        .clock (clock),
        .rst   (rst),
        .in    (out_q),
        .out   (product)
    );

endmodule

//--- hdl/mult_control.sv
module mult_control
    import mult_pkg::*;
(
    input  logic     clock,
    input  logic     rst,
    input  logic     in_valid,
    input  mult_op_t op,
    output logic     sign,
    input  product_t product,
    output logic     out_valid,
    output word_t    result
);

    logic       select_hi;
    logic [1:0] tag_in;
    logic [1:0] tag_out;
    logic       tag_valid;
    logic       tag_hi;

    // Decode the opcode into operand sign and word select
    always_comb begin
        case (op)
            op_mul: begin
                sign      = 1'b1;
                select_hi = 1'b0;
            end
            op_mulh: begin
                sign      = 1'b1;
                select_hi = 1'b1;
            end
            op_mulhu: begin
                sign      = 1'b0;
                select_hi = 1'b1;
            end
            default: begin
                sign      = 1'b1; // Reserved opcode behaves like op_mul
                select_hi = 1'b0;
            end
        endcase
    end

    assign tag_in = {in_valid, select_hi};

    // Tags ride beside the product so each operation keeps its own select
    delay_line #(
        .depth (ELEMENT_LATENCY),
        .width (2)
    ) i_tag_pipe (
        .clock (clock),
        .rst   (rst),
        .in    (tag_in),
        .out   (tag_out)
    );

    assign tag_valid = tag_out[1];
    assign tag_hi    = tag_out[0];

    always_ff @(posedge clock) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= tag_valid;
        end
    end

    // Only a valid product updates the result word
    always_ff @(posedge clock) begin
        if (tag_valid) begin
            if (tag_hi) begin
                result <= product[2*WORD_WIDTH-1:WORD_WIDTH];
            end else begin
                result <= product[WORD_WIDTH-1:0];
            end
        end
    end

endmodule

//--- hdl/mult_unit.sv
module mult_unit
    import mult_pkg::*;
(
    input  logic     clock,
    input  logic     rst,
    input  logic     in_valid,
    input  mult_op_t op,
    input  word_t    a,
    input  word_t    b,
    output logic     out_valid,
    output word_t    result
);

    logic     sign;    // Decoded from op in the same cycle as the operands
    product_t product;

    // Decode, tag pipeline and output word select
    mult_control i_mult_control (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (in_valid),
        .op        (op),
        .sign      (sign),
        .product   (product),
        .out_valid (out_valid),
        .result    (result)
    );

    // Fixed latency multiplier, a new operation every cycle
    mult_element i_mult_element (
        .clock   (clock),
        .rst     (rst),
        .sign    (sign),
        .dataa   (a),
        .datab   (b),
        .product (product)
    );

endmodule

//--- testbench/mult_unit_chk.sv
module mult_unit_chk
    import mult_pkg::*;
(
    input logic     clock,
    input logic     rst,
    input logic     in_valid,
    input mult_op_t op,
    input logic     out_valid,
    input word_t    result
);

    int unsigned assert_fails;
    int unsigned run_cycles;  // Edges since reset release, saturating
    bit          rst_seen;
    bit          rst_q;

    always @(posedge clock) begin
        rst_q <= rst;
        if (rst) begin
            rst_seen   <= 1'b1;
            run_cycles <= 0;
        end else if (run_cycles < UNIT_LATENCY) begin
            run_cycles <= run_cycles + 1;
        end
    end

    // Quiet output during reset and on the first edge after release
    reset_quiet: assert property (@(posedge clock) rst_seen && (rst || rst_q) |-> !out_valid)
        else begin assert_fails++; $error("out_valid high during or right after reset"); end

    latency_match: assert property (@(posedge clock) disable iff (rst)
        run_cycles >= UNIT_LATENCY |-> out_valid == $past(in_valid, UNIT_LATENCY))
        else begin assert_fails++; $error("out_valid does not follow in_valid by the latency"); end

    no_reserved_op: assert property (@(posedge clock) disable iff (rst)
        in_valid |-> op != 2'd3)
        else begin assert_fails++; $error("Reserved opcode issued with in_valid"); end

    result_known: assert property (@(posedge clock) disable iff (rst)
        out_valid |-> !$isunknown(result))
        else begin assert_fails++; $error("result unknown while out_valid is high"); end

endmodule

bind mult_unit mult_unit_chk i_mult_unit_chk (.*);

//--- testbench/tb_mult_unit.sv
module tb_mult_unit
    import mult_pkg::*;
();

    typedef logic [31:0] cycle_t;

    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 20;
    localparam int STREAM_OPS   = 200;
    localparam int GAP_CYCLES   = 200;
    localparam int DRAIN_LIMIT  = 4 * UNIT_LATENCY + 10;
    localparam int NUM_CORNERS  = 7;

    localparam word_t CORNERS [NUM_CORNERS] = '{
        32'h0000_0000,
        32'h0000_0001,
        32'hffff_ffff,
        32'h8000_0000, // Most negative
        32'h7fff_ffff, // Most positive
        32'h0001_0000,
        32'hffff_fffe
    };

    logic     clock;
    logic     rst;
    logic     in_valid;
    mult_op_t op;
    word_t    a;
    word_t    b;
    logic     out_valid;
    word_t    result;

    word_t       expected_q [$];
    cycle_t      due_q [$];   // Rising edge at which each expected result is sampled
    cycle_t      edge_count;
    logic [31:0] rng_state;

    mult_unit i_mult_unit (
        .clock     (clock),
        .rst       (rst),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result)
    );

    initial clock = 1'b0;

    always #20 clock = ~clock;

    always @(posedge clock) begin
        edge_count <= edge_count + 1'b1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic mult_op_t random_op();
        logic [31:0] r;
        r = next_random() % 3;
        return mult_op_t'(r[1:0]);
    endfunction

    // Mostly random words with a corner value now and then
    function automatic word_t random_operand();
        logic [31:0] r;
        r = next_random();
        if (r[2:0] == 3'd0) begin
            return CORNERS[r[31:8] % NUM_CORNERS];
        end
        return next_random();
    endfunction

    // Signed product unless the opcode asks for unsigned high word
    function automatic word_t expected_result(input mult_op_t f_op, input word_t x, input word_t y);
        logic signed [2*WORD_WIDTH-1:0] sx;
        logic signed [2*WORD_WIDTH-1:0] sy;
        logic signed [2*WORD_WIDTH-1:0] s_prod;
        logic [2*WORD_WIDTH-1:0]        ux;
        logic [2*WORD_WIDTH-1:0]        uy;
        logic [2*WORD_WIDTH-1:0]        u_prod;
        sx     = $signed(x);
        sy     = $signed(y);
        s_prod = sx * sy;
        ux     = x;
        uy     = y;
        u_prod = ux * uy;
        case (f_op)
            op_mulh:  return s_prod[2*WORD_WIDTH-1:WORD_WIDTH];
            op_mulhu: return u_prod[2*WORD_WIDTH-1:WORD_WIDTH];
            default:  return s_prod[WORD_WIDTH-1:0];
        endcase
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            report_failure($sformatf("ERR %s got %h expected %h", name, got, want));
        end
    endtask

    task automatic check_cycle(input string name, input cycle_t got, input cycle_t want);
        if (got !== want) begin
            report_failure($sformatf("ERR %s got %h expected %h", name, got, want));
        end
    endtask

    task automatic issue_op(input mult_op_t o, input word_t x, input word_t y);
        @(negedge clock);
        in_valid = 1'b1;
        op       = o;
        a        = x;
        b        = y;
        expected_q.push_back(expected_result(o, x, y));
        due_q.push_back(edge_count + 1 + UNIT_LATENCY); // Next rising edge samples the inputs
    endtask

    // Idle cycle with moving opcode and data that must be ignored
    task automatic idle_cycle();
        @(negedge clock);
        in_valid = 1'b0;
        op       = random_op();
        a        = next_random();
        b        = next_random();
    endtask

    task automatic check_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clock);
            if (out_valid !== 1'b0) begin
                report_failure("out_valid went high although no operation was issued");
            end
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge clock);
        in_valid = 1'b0;
        while (expected_q.size() != 0) begin
            if (waited >= DRAIN_LIMIT) begin
                report_failure("Timed out waiting for outstanding results to come out");
            end
            @(negedge clock);
            waited++;
        end
    endtask

    task automatic run_corners(input mult_op_t o);
        for (int i = 0; i < NUM_CORNERS; i++) begin
            for (int j = 0; j < NUM_CORNERS; j++) begin
                issue_op(o, CORNERS[i], CORNERS[j]);
            end
        end
    endtask

    task automatic run_stream(input int count);
        for (int i = 0; i < count; i++) begin
            issue_op(random_op(), random_operand(), random_operand());
        end
    endtask

    task automatic run_gaps(input int cycles);
        logic [31:0] r;
        for (int i = 0; i < cycles; i++) begin
            r = next_random();
            if (r[2:0] < 3'd5) begin
                issue_op(random_op(), random_operand(), random_operand());
            end else begin
                idle_cycle();
            end
        end
    endtask

    // Results are sampled on the rising edge like a downstream stage would
    always @(posedge clock) begin : compare_results
        word_t  want;
        cycle_t due;
        if (rst === 1'b0) begin
            if (i_mult_unit.i_mult_unit_chk.assert_fails != 0) begin
                report_failure("An assertion on the DUT ports failed");
            end
            if ($isunknown(out_valid)) begin
                report_failure("out_valid is unknown after reset");
            end
            if (out_valid) begin
                if (expected_q.size() == 0) begin
                    report_failure("out_valid was high with no operation outstanding");
                end
                want = expected_q.pop_front();
                due  = due_q.pop_front();
                check_cycle("out_valid edge", edge_count + 1, due);
                check_word("result", result, want);
            end
        end
    end

    initial begin
        rst           = 1'b1;
        in_valid      = 1'b0;
        op            = op_mul;
        a             = '0;
        b             = '0;
        edge_count    = '0;
        rng_state     = 32'hbdb4_c65f;

        repeat (RESET_CYCLES) @(negedge clock);
        rst = 1'b0;

        check_idle(IDLE_CYCLES);

        run_corners(op_mul);
        run_corners(op_mulh);
        wait_drain();
        run_corners(op_mulhu);
        wait_drain();

        run_stream(STREAM_OPS); // One result per cycle expected
        wait_drain();

        run_gaps(GAP_CYCLES);
        wait_drain();
        check_idle(2 * UNIT_LATENCY);

        if (i_mult_unit.i_mult_unit_chk.assert_fails == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_failure("An assertion on the DUT ports failed");
        end
    end

endmodule

//--- all.f
hdl/mult_pkg.sv
hdl/delay_line.sv
hdl/mult_element.sv
hdl/mult_control.sv
hdl/mult_unit.sv
testbench/mult_unit_chk.sv
testbench/tb_mult_unit.sv

//--- Bender.yml
package:
  name: mult_unit

dependencies: {}

sources:
  - hdl/mult_pkg.sv
  - hdl/delay_line.sv
  - hdl/mult_element.sv
  - hdl/mult_control.sv
  - hdl/mult_unit.sv
  - target: test
    files:
      - testbench/mult_unit_chk.sv
      - testbench/tb_mult_unit.sv
